// ==== hw/core_pkg.sv ====
`default_nettype none

package core_pkg;

  // instruction and register file geometry
  localparam int INSTR_WIDTH = 16;
  localparam int REG_INDEX_WIDTH = 3;
  localparam int OPCODE_WIDTH = 4;
  localparam int IMM_WIDTH = 6;

  // field positions inside an instruction word
  localparam int OPCODE_MSB = 15;
  localparam int OPCODE_LSB = 12;
  localparam int RD_MSB = 11;
  localparam int RD_LSB = 9;
  localparam int RS1_MSB = 8;
  localparam int RS1_LSB = 6;
  localparam int RS2_MSB = 5;
  localparam int RS2_LSB = 3;
  // imm shares its low bits with rs2
  localparam int IMM_MSB = 5;
  localparam int IMM_LSB = 0;

  // codes above OP_STORE are undefined and behave as nop
  typedef enum logic [OPCODE_WIDTH-1:0] {
    OP_NOP   = 4'd0,
    OP_ADD   = 4'd1,
    OP_SUB   = 4'd2,
    OP_AND   = 4'd3,
    OP_OR    = 4'd4,
    OP_XOR   = 4'd5,
    OP_SLT   = 4'd6,
    OP_ADDI  = 4'd7,
    OP_LOAD  = 4'd8,
    OP_STORE = 4'd9
  } opcode_t;

endpackage

`default_nettype wire

// ==== hw/register_file.sv ====
`timescale 1ns/100ps
`default_nettype none

module register_file
  import core_pkg::*;
#(
  parameter int DATA_WIDTH = 16
)
(
  input  wire logic                       clk,
  input  wire logic                       reset,
  input  wire logic [REG_INDEX_WIDTH-1:0] read_idx_1,
  input  wire logic [REG_INDEX_WIDTH-1:0] read_idx_2,
  input  wire logic                       write_enable,
  input  wire logic [REG_INDEX_WIDTH-1:0] write_idx,
  input  wire logic [DATA_WIDTH-1:0]      write_data,
  output logic      [DATA_WIDTH-1:0]      read_data_1,
  output logic      [DATA_WIDTH-1:0]      read_data_2
);

  localparam int NUM_REGS = 2 ** REG_INDEX_WIDTH;

  logic [DATA_WIDTH-1:0] regs [NUM_REGS];
  logic                  write_live;

  // r0 is never a real write target
  assign write_live = write_enable && (write_idx != '0);

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < NUM_REGS; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (write_live)
    begin
      regs[write_idx] <= write_data;
    end
  end

  // same-cycle write shows up on the read side,
  // so writeback needs no hazard check
  always_comb
  begin
    if (read_idx_1 == '0)
      read_data_1 = '0;
    else if (write_live && (write_idx == read_idx_1))
      read_data_1 = write_data;
    else
      read_data_1 = regs[read_idx_1];

    if (read_idx_2 == '0)
      read_data_2 = '0;
    else if (write_live && (write_idx == read_idx_2))
      read_data_2 = write_data;
    else
      read_data_2 = regs[read_idx_2];
  end

endmodule

`default_nettype wire

// ==== hw/decode_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module decode_stage
  import core_pkg::*;
#(
  parameter int DATA_WIDTH = 16
)
(
  input  wire logic                       clk,
  input  wire logic                       reset,
  input  wire logic                       instr_valid,
  input  wire logic [INSTR_WIDTH-1:0]     instr,
  input  wire logic                       stall,
  input  wire logic [DATA_WIDTH-1:0]      read_data_1,
  input  wire logic [DATA_WIDTH-1:0]      read_data_2,
  output logic      [REG_INDEX_WIDTH-1:0] read_idx_1,
  output logic      [REG_INDEX_WIDTH-1:0] read_idx_2,
  output logic      [REG_INDEX_WIDTH-1:0] decode_src_1,
  output logic      [REG_INDEX_WIDTH-1:0] decode_src_2,
  output opcode_t                         ex_op,
  output logic      [REG_INDEX_WIDTH-1:0] ex_dst,
  output logic      [DATA_WIDTH-1:0]      ex_operand_a,
  output logic      [DATA_WIDTH-1:0]      ex_operand_b,
  output logic      [DATA_WIDTH-1:0]      ex_imm,
  output logic      [DATA_WIDTH-1:0]      ex_store_data
);

  logic                       dec_valid;
  logic [INSTR_WIDTH-1:0]     dec_instr;
  logic [OPCODE_WIDTH-1:0]    raw_op;
  opcode_t                    dec_op;
  logic [REG_INDEX_WIDTH-1:0] field_rd;
  logic [REG_INDEX_WIDTH-1:0] field_rs1;
  logic [REG_INDEX_WIDTH-1:0] field_rs2;
  logic [IMM_WIDTH-1:0]       field_imm;
  logic [REG_INDEX_WIDTH-1:0] dec_dst;

  // decode register, frozen while stalled
  // a free slot just takes whatever sits on the input
  always_ff @(posedge clk)
  begin
    if (reset)
      dec_valid <= 1'b0;
    else if (!stall)
      dec_valid <= instr_valid;
  end

  always_ff @(posedge clk)
  begin
    if (!stall)
      dec_instr <= instr;
  end

  // field split
  assign raw_op    = dec_instr[OPCODE_MSB:OPCODE_LSB];
  assign field_rd  = dec_instr[RD_MSB:RD_LSB];
  assign field_rs1 = dec_instr[RS1_MSB:RS1_LSB];
  assign field_rs2 = dec_instr[RS2_MSB:RS2_LSB];
  assign field_imm = dec_instr[IMM_MSB:IMM_LSB];

  // empty slot and undefined codes both become nop
  always_comb
  begin
    dec_op = OP_NOP;
    if (dec_valid && (raw_op <= OP_STORE))
      dec_op = opcode_t'(raw_op);
  end

  // only the sources an op really reads reach the hazard unit
  always_comb
  begin
    decode_src_1 = '0;
    decode_src_2 = '0;
    dec_dst      = '0;
    case (dec_op)
      OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT:
      begin
        decode_src_1 = field_rs1;
        decode_src_2 = field_rs2;
        dec_dst      = field_rd;
      end
      OP_ADDI, OP_LOAD:
      begin
        decode_src_1 = field_rs1;
        dec_dst      = field_rd;
      end
      // store reads rd as its data source
      OP_STORE:
      begin
        decode_src_1 = field_rs1;
        decode_src_2 = field_rd;
      end
      default:
      begin
        dec_dst = '0;
      end
    endcase
  end

  assign read_idx_1 = decode_src_1;
  assign read_idx_2 = decode_src_2;

  // execute register, bubble on stall
  always_ff @(posedge clk)
  begin
    if (reset || stall)
    begin
      ex_op  <= OP_NOP;
      ex_dst <= '0;
    end
    else
    begin
      ex_op  <= dec_op;
      ex_dst <= dec_dst;
    end
  end

  // operands follow along, a bubble never looks at them
  always_ff @(posedge clk)
  begin
    ex_operand_a  <= read_data_1;
    ex_operand_b  <= read_data_2;
    ex_store_data <= read_data_2;
    ex_imm        <= {{(DATA_WIDTH-IMM_WIDTH){field_imm[IMM_WIDTH-1]}}, field_imm};
  end

endmodule

`default_nettype wire

// ==== hw/hazard_detection_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module hazard_detection_unit
  import core_pkg::*;
(
  input  wire logic [REG_INDEX_WIDTH-1:0] decode_src_1,
  input  wire logic [REG_INDEX_WIDTH-1:0] decode_src_2,
  input  wire logic [REG_INDEX_WIDTH-1:0] execute_dst,
  input  wire logic [REG_INDEX_WIDTH-1:0] memory_dst,
  output logic                            stall
);

  logic src_1_busy;
  logic src_2_busy;

  // no forwarding, so any in-flight producer blocks the read
  // a zero source is r0 or unused and never matches
  // a zero destination is a nop, store or bubble
  // writeback is covered by the register file bypass
  assign src_1_busy = (decode_src_1 != '0) &&
                      ((decode_src_1 == execute_dst) || (decode_src_1 == memory_dst));
  assign src_2_busy = (decode_src_2 != '0) &&
                      ((decode_src_2 == execute_dst) || (decode_src_2 == memory_dst));

  // one rule for data, load-use and store-use
  // combinational so the stalled instruction is the one in decode now
  assign stall = src_1_busy || src_2_busy;

endmodule

`default_nettype wire

// ==== hw/execute_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module execute_stage
  import core_pkg::*;
#(
  parameter int DATA_WIDTH = 16
)
(
  input  wire logic                       clk,
  input  wire logic                       reset,
  input  wire opcode_t                    ex_op,
  input  wire logic [REG_INDEX_WIDTH-1:0] ex_dst,
  input  wire logic [DATA_WIDTH-1:0]      ex_operand_a,
  input  wire logic [DATA_WIDTH-1:0]      ex_operand_b,
  input  wire logic [DATA_WIDTH-1:0]      ex_imm,
  input  wire logic [DATA_WIDTH-1:0]      ex_store_data,
  output logic      [REG_INDEX_WIDTH-1:0] execute_dst,
  output opcode_t                         mem_op,
  output logic      [REG_INDEX_WIDTH-1:0] mem_dst,
  output logic      [DATA_WIDTH-1:0]      mem_result,
  output logic      [DATA_WIDTH-1:0]      mem_store_data
);

  logic [DATA_WIDTH-1:0] alu_result;

  // destination held in execute, seen by the hazard unit
  assign execute_dst = ex_dst;

  always_comb
  begin
    alu_result = '0;
    case (ex_op)
      OP_ADD: alu_result = ex_operand_a + ex_operand_b;
      OP_SUB: alu_result = ex_operand_a - ex_operand_b;
      OP_AND: alu_result = ex_operand_a & ex_operand_b;
      OP_OR:  alu_result = ex_operand_a | ex_operand_b;
      OP_XOR: alu_result = ex_operand_a ^ ex_operand_b;
      // signed compare, result is 0 or 1
      OP_SLT: alu_result[0] = $signed(ex_operand_a) < $signed(ex_operand_b);
      // immediate add, also the load/store address
      OP_ADDI, OP_LOAD, OP_STORE:
        alu_result = ex_operand_a + ex_imm;
      default: alu_result = '0;
    endcase
  end

  // memory register control
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      mem_op  <= OP_NOP;
      mem_dst <= '0;
    end
    else
    begin
      mem_op  <= ex_op;
      mem_dst <= ex_dst;
    end
  end

  // memory register payload
  always_ff @(posedge clk)
  begin
    mem_result     <= alu_result;
    mem_store_data <= ex_store_data;
  end

endmodule

`default_nettype wire

// ==== hw/memory_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module memory_stage
  import core_pkg::*;
#(
  parameter int DATA_WIDTH = 16,
  parameter int DMEM_DEPTH = 64
)
(
  input  wire logic                       clk,
  input  wire logic                       reset,
  input  wire opcode_t                    mem_op,
  input  wire logic [REG_INDEX_WIDTH-1:0] mem_dst,
  input  wire logic [DATA_WIDTH-1:0]      mem_result,
  input  wire logic [DATA_WIDTH-1:0]      mem_store_data,
  output logic      [REG_INDEX_WIDTH-1:0] memory_dst,
  output logic                            wb_valid,
  output logic      [REG_INDEX_WIDTH-1:0] wb_idx,
  output logic      [DATA_WIDTH-1:0]      wb_data
);

  localparam int ADDR_WIDTH = $clog2(DMEM_DEPTH);

  logic [DATA_WIDTH-1:0] dmem [DMEM_DEPTH];
  logic [ADDR_WIDTH-1:0] addr;

  // destination held in memory, seen by the hazard unit
  assign memory_dst = mem_dst;

  // low bits only, addresses wrap
  assign addr = mem_result[ADDR_WIDTH-1:0];

  // memory starts out all zero after reset
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < DMEM_DEPTH; i++)
      begin
        dmem[i] <= '0;
      end
    end
    else if (mem_op == OP_STORE)
    begin
      dmem[addr] <= mem_store_data;
    end
  end

  // writeback register control
  // r0, store, nop and bubble all carry dst 0 and never pulse
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wb_valid <= 1'b0;
      wb_idx   <= '0;
    end
    else
    begin
      wb_valid <= (mem_dst != '0);
      wb_idx   <= mem_dst;
    end
  end

  // load data or the alu result
  always_ff @(posedge clk)
  begin
    wb_data <= (mem_op == OP_LOAD) ? dmem[addr] : mem_result;
  end

endmodule

`default_nettype wire

// ==== hw/pipeline_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module pipeline_top
  import core_pkg::*;
#(
  parameter int DATA_WIDTH = 16,
  parameter int DMEM_DEPTH = 64
)
(
  input  wire logic                       clk,
  input  wire logic                       reset,
  input  wire logic                       instr_valid,
  input  wire logic [INSTR_WIDTH-1:0]     instr,
  output logic                            stall,
  output logic                            wb_valid,
  output logic      [REG_INDEX_WIDTH-1:0] wb_idx,
  output logic      [DATA_WIDTH-1:0]      wb_data
);

  // register file ports
  logic [REG_INDEX_WIDTH-1:0] read_idx_1;
  logic [REG_INDEX_WIDTH-1:0] read_idx_2;
  logic [DATA_WIDTH-1:0]      read_data_1;
  logic [DATA_WIDTH-1:0]      read_data_2;

  // hazard compare inputs
  logic [REG_INDEX_WIDTH-1:0] decode_src_1;
  logic [REG_INDEX_WIDTH-1:0] decode_src_2;
  logic [REG_INDEX_WIDTH-1:0] execute_dst;
  logic [REG_INDEX_WIDTH-1:0] memory_dst;

  // execute register
  opcode_t                    ex_op;
  logic [REG_INDEX_WIDTH-1:0] ex_dst;
  logic [DATA_WIDTH-1:0]      ex_operand_a;
  logic [DATA_WIDTH-1:0]      ex_operand_b;
  logic [DATA_WIDTH-1:0]      ex_imm;
  logic [DATA_WIDTH-1:0]      ex_store_data;

  // memory register
  opcode_t                    mem_op;
  logic [REG_INDEX_WIDTH-1:0] mem_dst;
  logic [DATA_WIDTH-1:0]      mem_result;
  logic [DATA_WIDTH-1:0]      mem_store_data;

  // writeback strobe doubles as the write port
  register_file #(.DATA_WIDTH(DATA_WIDTH)) u_register_file (
    .clk(clk), .reset(reset),
    .read_idx_1(read_idx_1), .read_idx_2(read_idx_2),
    .write_enable(wb_valid), .write_idx(wb_idx), .write_data(wb_data),
    .read_data_1(read_data_1), .read_data_2(read_data_2)
  );

  decode_stage #(.DATA_WIDTH(DATA_WIDTH)) u_decode_stage (
    .clk(clk), .reset(reset), .instr_valid(instr_valid), .instr(instr), .stall(stall),
    .read_data_1(read_data_1), .read_data_2(read_data_2),
    .read_idx_1(read_idx_1), .read_idx_2(read_idx_2),
    .decode_src_1(decode_src_1), .decode_src_2(decode_src_2),
    .ex_op(ex_op), .ex_dst(ex_dst), .ex_operand_a(ex_operand_a),
    .ex_operand_b(ex_operand_b), .ex_imm(ex_imm), .ex_store_data(ex_store_data)
  );

  hazard_detection_unit u_hazard_detection_unit (
    .decode_src_1(decode_src_1), .decode_src_2(decode_src_2),
    .execute_dst(execute_dst), .memory_dst(memory_dst), .stall(stall)
  );

  execute_stage #(.DATA_WIDTH(DATA_WIDTH)) u_execute_stage (
    .clk(clk), .reset(reset), .ex_op(ex_op), .ex_dst(ex_dst),
    .ex_operand_a(ex_operand_a), .ex_operand_b(ex_operand_b),
    .ex_imm(ex_imm), .ex_store_data(ex_store_data), .execute_dst(execute_dst),
    .mem_op(mem_op), .mem_dst(mem_dst), .mem_result(mem_result),
    .mem_store_data(mem_store_data)
  );

  memory_stage #(.DATA_WIDTH(DATA_WIDTH), .DMEM_DEPTH(DMEM_DEPTH)) u_memory_stage (
    .clk(clk), .reset(reset), .mem_op(mem_op), .mem_dst(mem_dst),
    .mem_result(mem_result), .mem_store_data(mem_store_data),
    .memory_dst(memory_dst), .wb_valid(wb_valid), .wb_idx(wb_idx), .wb_data(wb_data)
  );

endmodule

`default_nettype wire

// ==== sim/pipeline_asserts.sv ====
`timescale 1ns/100ps
`default_nettype none

module pipeline_asserts
  import core_pkg::*;
(
  input wire logic                       clk,
  input wire logic                       reset,
  input wire logic                       instr_valid,
  input wire logic [INSTR_WIDTH-1:0]     instr,
  input wire logic                       stall,
  input wire logic                       wb_valid,
  input wire logic [REG_INDEX_WIDTH-1:0] wb_idx
);

  logic [OPCODE_WIDTH-1:0] instr_op;
  logic                    writes_reg;
  int                      write_accepts;
  int                      wb_total;
  int                      wb_idx_fails = 0;
  int                      reset_stall_fails = 0;
  int                      order_fails = 0;
  int                      failures;

  assign failures = wb_idx_fails + reset_stall_fails + order_fails;

  // ops that name a destination, r0 never counts
  assign instr_op   = instr[OPCODE_MSB:OPCODE_LSB];
  assign writes_reg = (instr_op >= OP_ADD) && (instr_op <= OP_LOAD) &&
                      (instr[RD_MSB:RD_LSB] != '0);

  // running totals of accepted writers and writebacks
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      write_accepts <= 0;
      wb_total      <= 0;
    end
    else
    begin
      if (instr_valid && !stall && writes_reg)
        write_accepts <= write_accepts + 1;
      if (wb_valid)
        wb_total <= wb_total + 1;
    end
  end

  // r0 never pulses writeback
  wb_idx_nonzero: assert property (@(posedge clk) disable iff (reset)
    wb_valid |-> (wb_idx != '0))
  else
  begin
    wb_idx_fails++;
    $error("writeback strobe carries index 0");
  end

  // first cycle out of reset
  stall_low_after_reset: assert property (@(posedge clk) $fell(reset) |-> !stall)
  else
  begin
    reset_stall_fails++;
    $error("stall high in the first cycle after reset");
  end

  // every writeback needs its own writing accept at least three edges back
  wb_has_source: assert property (@(posedge clk) disable iff (reset)
    wb_valid |-> (wb_total < $past(write_accepts, 3)))
  else
  begin
    order_fails++;
    $error("writeback without a matching accepted instruction");
  end

endmodule

bind pipeline_top pipeline_asserts u_asserts (
  .clk(clk), .reset(reset), .instr_valid(instr_valid), .instr(instr), .stall(stall),
  .wb_valid(wb_valid), .wb_idx(wb_idx)
);

`default_nettype wire

// ==== sim/pipeline_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module pipeline_checker
  import core_pkg::*;
#(
  parameter int DATA_WIDTH = 16,
  parameter int DMEM_DEPTH = 64
)
(
  input  wire logic                       clk,
  input  wire logic                       reset,
  input  wire logic                       instr_valid,
  input  wire logic [INSTR_WIDTH-1:0]     instr,
  input  wire logic                       stall,
  input  wire logic                       wb_valid,
  input  wire logic [REG_INDEX_WIDTH-1:0] wb_idx,
  input  wire logic [DATA_WIDTH-1:0]      wb_data,
  input  wire logic                       test_end,
  input  var int                          test_index,
  input  wire logic                       expect_no_stall,
  input  wire logic                       expect_stall,
  output int                              error_count,
  output int                              tests_passed,
  output int                              tests_failed,
  output int                              pending,
  output int                              checks
);

  localparam int NUM_REGS = 2 ** REG_INDEX_WIDTH;
  localparam int ADDR_WIDTH = $clog2(DMEM_DEPTH);

  // architectural state
  logic [DATA_WIDTH-1:0]      model_regs [NUM_REGS];
  logic [DATA_WIDTH-1:0]      model_mem [DMEM_DEPTH];
  // expected writebacks, oldest first
  logic [REG_INDEX_WIDTH-1:0] exp_idx_q [$];
  logic [DATA_WIDTH-1:0]      exp_data_q [$];
  logic                       prev_reset = 1'b0;
  int                         test_errors;
  int                         test_wbs;
  int                         test_stalls;

  task automatic note_error();
    error_count++;
    test_errors++;
  endtask

  // one accepted instruction, in program order
  task automatic execute_model(input logic [INSTR_WIDTH-1:0] word);
    logic [REG_INDEX_WIDTH-1:0] rd;
    logic [DATA_WIDTH-1:0]      a;
    logic [DATA_WIDTH-1:0]      b;
    logic [DATA_WIDTH-1:0]      imm;
    logic [DATA_WIDTH-1:0]      value;
    logic [ADDR_WIDTH-1:0]      addr;
    logic                       writes;
    rd     = word[RD_MSB:RD_LSB];
    a      = model_regs[word[RS1_MSB:RS1_LSB]];
    b      = model_regs[word[RS2_MSB:RS2_LSB]];
    imm    = DATA_WIDTH'($signed(word[IMM_MSB:IMM_LSB]));
    // address wraps with the memory depth
    addr   = ADDR_WIDTH'(a + imm);
    value  = '0;
    writes = 1'b1;
    case (word[OPCODE_MSB:OPCODE_LSB])
      OP_ADD:  value = a + b;
      OP_SUB:  value = a - b;
      OP_AND:  value = a & b;
      OP_OR:   value = a | b;
      OP_XOR:  value = a ^ b;
      OP_SLT:  value = ($signed(a) < $signed(b)) ? DATA_WIDTH'(1) : '0;
      OP_ADDI: value = a + imm;
      OP_LOAD: value = model_mem[addr];
      // rd is the data source here
      OP_STORE:
      begin
        model_mem[addr] = model_regs[rd];
        writes = 1'b0;
      end
      default: writes = 1'b0;
    endcase
    if (writes && (rd != '0))
    begin
      model_regs[rd] = value;
      exp_idx_q.push_back(rd);
      exp_data_q.push_back(value);
    end
  endtask

  task automatic compare_writeback();
    logic [REG_INDEX_WIDTH-1:0] exp_idx;
    logic [DATA_WIDTH-1:0]      exp_data;
    test_wbs++;
    checks++;
    if (exp_idx_q.size() == 0)
    begin
      $display("test %0d: writeback to r%0d (data 0x%h) with no instruction waiting for it",
               test_index, wb_idx, wb_data);
      note_error();
    end
    else
    begin
      exp_idx  = exp_idx_q.pop_front();
      exp_data = exp_data_q.pop_front();
      if (wb_idx !== exp_idx)
      begin
        $display("[FAIL] wb_idx: expected 0x%h, got 0x%h", exp_idx, wb_idx);
        note_error();
      end
      if (wb_data !== exp_data)
      begin
        $display("[FAIL] wb_data: expected 0x%h, got 0x%h", exp_data, wb_data);
        note_error();
      end
    end
  endtask

  // per-test verdict, then a fresh start
  task automatic close_test();
    if (exp_idx_q.size() != 0)
    begin
      $display("test %0d: %0d expected writebacks never appeared", test_index, exp_idx_q.size());
      note_error();
      exp_idx_q.delete();
      exp_data_q.delete();
    end
    if (expect_no_stall && (test_stalls != 0))
    begin
      $display("test %0d: stall was high for %0d cycles though no sources collided",
               test_index, test_stalls);
      note_error();
    end
    if (expect_stall && (test_stalls == 0))
    begin
      $display("test %0d: dependent instructions never raised stall", test_index);
      note_error();
    end
    if (test_errors == 0)
    begin
      tests_passed++;
      $display("test %0d passed: %0d writebacks, %0d stall cycles",
               test_index, test_wbs, test_stalls);
    end
    else
    begin
      tests_failed++;
      $display("test %0d failed: %0d writebacks, %0d stall cycles, %0d mismatches",
               test_index, test_wbs, test_stalls, test_errors);
    end
    test_errors = 0;
    test_wbs    = 0;
    test_stalls = 0;
  endtask

  always @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < NUM_REGS; i++)
        model_regs[i] = '0;
      for (int i = 0; i < DMEM_DEPTH; i++)
        model_mem[i] = '0;
      exp_idx_q.delete();
      exp_data_q.delete();
      error_count  = 0;
      tests_passed = 0;
      tests_failed = 0;
      checks       = 0;
      test_errors  = 0;
      test_wbs     = 0;
      test_stalls  = 0;
    end
    else
    begin
      // quiet pipeline right out of reset
      if (prev_reset && (stall !== 1'b0))
      begin
        $display("[FAIL] stall: expected 0x0, got 0x%h", stall);
        note_error();
      end
      if (prev_reset && (wb_valid !== 1'b0))
      begin
        $display("[FAIL] wb_valid: expected 0x0, got 0x%h", wb_valid);
        note_error();
      end
      if (stall)
        test_stalls++;
      if (wb_valid)
        compare_writeback();
      if (instr_valid && !stall)
        execute_model(instr);
      if (test_end)
        close_test();
    end
    pending    = exp_idx_q.size();
    prev_reset = reset;
  end

endmodule

`default_nettype wire

// ==== sim/pipeline_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module pipeline_tb
  import core_pkg::*;
();

  localparam int DATA_WIDTH = 16;
  localparam int DMEM_DEPTH = 64;

  // instructions issued per test
  localparam int T1_COUNT = 7;
  localparam int T2_COUNT = 40;
  localparam int T3_COUNT = 30;
  localparam int T4_ROUNDS = 6;
  localparam int T4_COUNT = T4_ROUNDS * 9;
  localparam int T5_COUNT = 24;
  localparam int T6_COUNT = 200;
  localparam int TOTAL_COUNT = T1_COUNT + T2_COUNT + T3_COUNT + T4_COUNT + T5_COUNT + T6_COUNT;
  localparam int CYCLE_LIMIT = TOTAL_COUNT * 6 + 100;

  logic                       clk = 1'b0;
  logic                       reset;
  logic                       instr_valid;
  logic [INSTR_WIDTH-1:0]     instr;
  logic                       stall;
  logic                       wb_valid;
  logic [REG_INDEX_WIDTH-1:0] wb_idx;
  logic [DATA_WIDTH-1:0]      wb_data;
  logic                       test_end;
  logic                       expect_no_stall;
  logic                       expect_stall;
  int                         test_index;
  int                         error_count;
  int                         tests_passed;
  int                         tests_failed;
  int                         pending;
  int                         checks;
  int                         cycle_count = 0;
  integer                     seed;

  always #50 clk = ~clk;

  pipeline_top #(.DATA_WIDTH(DATA_WIDTH), .DMEM_DEPTH(DMEM_DEPTH)) uut (
    .clk(clk), .reset(reset), .instr_valid(instr_valid), .instr(instr),
    .stall(stall), .wb_valid(wb_valid), .wb_idx(wb_idx), .wb_data(wb_data)
  );

  pipeline_checker #(.DATA_WIDTH(DATA_WIDTH), .DMEM_DEPTH(DMEM_DEPTH)) u_checker (
    .clk(clk), .reset(reset), .instr_valid(instr_valid), .instr(instr), .stall(stall),
    .wb_valid(wb_valid), .wb_idx(wb_idx), .wb_data(wb_data),
    .test_end(test_end), .test_index(test_index),
    .expect_no_stall(expect_no_stall), .expect_stall(expect_stall),
    .error_count(error_count), .tests_passed(tests_passed), .tests_failed(tests_failed),
    .pending(pending), .checks(checks)
  );

  // watchdog
  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT)
    begin
      $display("timeout: run still going after %0d cycles", CYCLE_LIMIT);
      $display("Errors found");
      $finish;
    end
  end

  function automatic int rand_below(input int bound);
    return int'($unsigned($random(seed)) % bound);
  endfunction

  function automatic logic [INSTR_WIDTH-1:0] encode_reg(input opcode_t op,
      input logic [2:0] rd, input logic [2:0] rs1, input logic [2:0] rs2);
    return {op, rd, rs1, rs2, 3'b000};
  endfunction

  function automatic logic [INSTR_WIDTH-1:0] encode_imm(input opcode_t op,
      input logic [2:0] rd, input logic [2:0] rs1, input logic [5:0] imm);
    return {op, rd, rs1, imm};
  endfunction

  // a source that nothing in execute or memory will write
  function automatic logic [2:0] free_source(input logic [2:0] busy_1,
      input logic [2:0] busy_2);
    logic [2:0] pick;
    pick = 3'(rand_below(8));
    while ((pick != 3'd0) && ((pick == busy_1) || (pick == busy_2)))
      pick = 3'(rand_below(8));
    return pick;
  endfunction

  task automatic begin_test(input int index, input logic no_stall, input logic must_stall);
    test_index      = index;
    expect_no_stall = no_stall;
    expect_stall    = must_stall;
  endtask

  // held steady until a cycle with stall low takes it
  task automatic issue(input logic [INSTR_WIDTH-1:0] word);
    logic taken;
    instr_valid = 1'b1;
    instr       = word;
    taken       = 1'b0;
    while (!taken)
    begin
      taken = !stall;
      @(negedge clk);
    end
    instr_valid = 1'b0;
  endtask

  // drain, bounded, then pulse test_end
  task automatic finish_test();
    int waited;
    waited = 0;
    while (((pending != 0) || (waited < 3)) && (waited < 12))
    begin
      @(negedge clk);
      waited++;
    end
    test_end = 1'b1;
    @(negedge clk);
    test_end = 1'b0;
  endtask

  initial
  begin
    logic [2:0] rd;
    logic [2:0] rs1;
    logic [2:0] d1;
    logic [2:0] d2;
    logic [5:0] offset;
    seed            = 3539;
    reset           = 1'b1;
    instr_valid     = 1'b0;
    instr           = '0;
    test_end        = 1'b0;
    test_index      = 1;
    expect_no_stall = 1'b0;
    expect_stall    = 1'b0;
    repeat (10) @(negedge clk);
    reset = 1'b0;

    // every register reads zero after reset
    begin_test(1, 1'b1, 1'b0);
    for (int r = 1; r <= T1_COUNT; r++)
      issue(encode_reg(OP_ADD, 3'(r), 3'(r), 3'd0));
    finish_test();

    // no source hits the two previous destinations
    begin_test(2, 1'b1, 1'b0);
    d1 = 3'd0;
    d2 = 3'd0;
    for (int n = 0; n < T2_COUNT; n++)
    begin
      rd = 3'(1 + rand_below(7));
      if (rand_below(3) == 0)
        issue(encode_imm(OP_ADDI, rd, free_source(d1, d2), 6'(rand_below(64))));
      else
        issue(encode_reg(opcode_t'(4'(1 + rand_below(6))), rd,
                         free_source(d1, d2), free_source(d1, d2)));
      d2 = d1;
      d1 = rd;
    end
    finish_test();

    // chain, each reads the last result
    begin_test(3, 1'b0, 1'b1);
    rd = 3'd1;
    for (int n = 0; n < T3_COUNT; n++)
    begin
      rs1 = rd;
      rd  = 3'(1 + rand_below(7));
      if (rand_below(2) == 0)
        issue(encode_imm(OP_ADDI, rd, rs1, 6'(rand_below(64))));
      else
        issue(encode_reg(opcode_t'(4'(1 + rand_below(6))), rd, rs1, 3'(rand_below(8))));
    end
    finish_test();

    // store, reload, aliased reload 64 words down, use right away
    begin_test(4, 1'b0, 1'b0);
    for (int n = 0; n < T4_ROUNDS; n++)
    begin
      offset = 6'(rand_below(64));
      issue(encode_imm(OP_ADDI, 3'd1, 3'd0, 6'(rand_below(64))));
      issue(encode_imm(OP_ADDI, 3'd2, 3'd0, 6'(rand_below(64))));
      issue(encode_imm(OP_STORE, 3'd1, 3'd2, offset));
      issue(encode_imm(OP_LOAD, 3'd3, 3'd2, offset));
      issue(encode_imm(OP_ADDI, 3'd4, 3'd2, 6'h20));
      issue(encode_imm(OP_ADDI, 3'd4, 3'd4, 6'h20));
      issue(encode_imm(OP_LOAD, 3'd5, 3'd4, offset));
      issue(encode_reg(OP_ADD, 3'd6, 3'd5, 3'd1));
      issue(encode_imm(OP_STORE, 3'd6, 3'd4, 6'(rand_below(64))));
    end
    finish_test();

    // writes to r0, then r0 read back
    begin_test(5, 1'b1, 1'b0);
    for (int n = 0; n < T5_COUNT - 4; n++)
      issue(encode_imm(opcode_t'(4'(1 + rand_below(8))), 3'd0,
                       3'(rand_below(8)), 6'(rand_below(64))));
    for (int r = 1; r <= 4; r++)
      issue(encode_reg(OP_ADD, 3'(r), 3'd0, 3'd0));
    finish_test();

    // raw random words, undefined opcodes included
    begin_test(6, 1'b0, 1'b0);
    for (int n = 0; n < T6_COUNT; n++)
      issue(16'(rand_below(65536)));
    finish_test();

    $display("closing: %0d tests passed, %0d tests failed, %0d writebacks checked, %0d mismatches",
             tests_passed, tests_failed, checks, error_count);
    if ((error_count == 0) && (uut.u_asserts.failures == 0))
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
hw/core_pkg.sv
hw/register_file.sv
hw/decode_stage.sv
hw/hazard_detection_unit.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/pipeline_top.sv
sim/pipeline_asserts.sv
sim/pipeline_checker.sv
sim/pipeline_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= pipeline_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  := No errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, look for the pass line"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
